//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_spi_master -f tb.f \
  && ./obj_dir/Vtb_spi_master | tee /dev/stderr | grep -q "All tests passed" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

//--- spi_bit_timer.sv
`timescale 1ns/1ps

module spi_bit_timer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              run,
  output logic                              sclk,
  output logic                              rise,
  output logic                              fall,
  output logic [spi_cfg_pkg::CNT_WIDTH-1:0] bit_cnt
);
  import spi_cfg_pkg::*;

  logic [DIV_WIDTH-1:0] div_cnt;
  logic                 half_done;

  // The edge pulses lead the sclk register by one cycle, so anything
  // clocked on them changes together with sclk.
  assign half_done = run && (div_cnt == DIV_WIDTH'(SCLK_HALF - 1));
  assign rise      = half_done && !sclk;
  assign fall      = half_done && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      sclk    <= 1'b0;
      bit_cnt <= '0;
    end
    else if (!run)
    begin
      div_cnt <= '0;
      sclk    <= 1'b0;  // Mode 0 idles low.
      bit_cnt <= '0;
    end
    else
    begin
      if (half_done)
      begin
        div_cnt <= '0;
        sclk    <= !sclk;
      end
      else
        div_cnt <= div_cnt + 1'b1;
      if (rise)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

endmodule

//--- spi_cfg_pkg.sv
package spi_cfg_pkg;

  // --------------------
  // Bus timing
  // --------------------

  // System clock cycles per sclk half period.
  localparam int SCLK_HALF = 2;

  localparam int DIV_WIDTH = $clog2(SCLK_HALF) + 1; // Holds 0 to SCLK_HALF-1.

  // --------------------
  // Frame geometry
  // --------------------

  localparam int CMD_WIDTH  = 12;  // Opcode, address and write data.
  localparam int READ_WIDTH = 8;
  localparam int HDR_BITS   = 4;   // Opcode and address go out before a read turns around.

  // Counts rising sclk edges up to CMD_WIDTH.
  localparam int CNT_WIDTH  = 4;

endpackage

//--- spi_cmd_pkg.sv
package spi_cmd_pkg;

  // --------------------
  // Command format
  // --------------------

  // The opcode sits in the MSB, ahead of the 3-bit address and the data byte.
  localparam int OP_BIT = spi_cfg_pkg::CMD_WIDTH - 1;

  typedef logic [spi_cfg_pkg::CMD_WIDTH-1:0]  cmd_t;
  typedef logic [spi_cfg_pkg::READ_WIDTH-1:0] rdata_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_e;

  // --------------------
  // Controller states
  // --------------------

  typedef enum logic [2:0] {
    ST_IDLE,   // Ready for a command, chip select high.
    ST_SETUP,  // Chip select low, first bit settling on mosi.
    ST_SEND,   // Clocking command bits out.
    ST_RECV,   // Clocking read data in.
    ST_HOLD,   // Chip select held after the last falling edge.
    ST_GAP     // Chip select high before the next command.
  } ctrl_state_e;

endpackage

//--- spi_ctrl_fsm.sv
`timescale 1ns/1ps

module spi_ctrl_fsm (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              cmd_vld,
  input  spi_cmd_pkg::spi_op_e              op,
  input  logic [spi_cfg_pkg::CNT_WIDTH-1:0] bit_cnt,
  input  logic                              fall,
  output logic                              cmd_rdy,
  output logic                              cs_n,
  output logic                              run,
  output logic                              load,
  output logic                              sample_en,
  output logic                              read_vld
);
  import spi_cfg_pkg::*;
  import spi_cmd_pkg::*;

  ctrl_state_e          state;
  ctrl_state_e          state_nxt;
  spi_op_e              op_q;
  logic [DIV_WIDTH-1:0] phase;
  logic                 phase_done;
  logic                 timed_state;
  logic                 last_fall;
  logic                 hdr_fall;

  // SETUP, HOLD and GAP each last one sclk half period.
  assign timed_state = (state == ST_SETUP) || (state == ST_HOLD) || (state == ST_GAP);
  assign phase_done  = (phase == DIV_WIDTH'(SCLK_HALF - 1));

  // The falling edge after the last rising edge closes a phase.
  assign last_fall = fall && (bit_cnt == CNT_WIDTH'(CMD_WIDTH));
  assign hdr_fall  = fall && (bit_cnt == CNT_WIDTH'(HDR_BITS));

  // --------------------
  // Next state
  // --------------------

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
        if (cmd_vld)
          state_nxt = ST_SETUP;
      ST_SETUP:
        if (phase_done)
          state_nxt = ST_SEND;
      ST_SEND:
        if (op_q == OP_WRITE)
        begin
          if (last_fall)
            state_nxt = ST_HOLD;
        end
        else if (hdr_fall)
          state_nxt = ST_RECV;  // Header is out, the slave now drives miso.
      ST_RECV:
        if (last_fall)
          state_nxt = ST_HOLD;
      ST_HOLD:
        if (phase_done)
          state_nxt = ST_GAP;
      ST_GAP:
        if (phase_done)
          state_nxt = ST_IDLE;
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  // --------------------
  // State registers
  // --------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      phase    <= '0;
      op_q     <= OP_READ;
      cs_n     <= 1'b1;
      read_vld <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (state_nxt != state)
        phase <= '0;
      else if (timed_state)
        phase <= phase + 1'b1;
      if (load)
        op_q <= op;
      // Registered so chip select follows the state without glitches.
      cs_n     <= (state_nxt == ST_IDLE) || (state_nxt == ST_GAP);
      read_vld <= (state == ST_HOLD) && (state_nxt == ST_GAP) && (op_q == OP_READ);
    end
  end

  assign cmd_rdy   = (state == ST_IDLE);
  assign load      = cmd_rdy && cmd_vld;  // Accepted command goes straight into the shifter.
  assign run       = (state == ST_SEND) || (state == ST_RECV);
  assign sample_en = (state == ST_RECV);

endmodule

//--- spi_master.sv
`timescale 1ns/1ps

module spi_master (
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_cmd_pkg::cmd_t     cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic                  sclk,
  output logic                  cs_n,
  output logic                  mosi,
  input  logic                  miso,
  output logic                  read_vld,
  output spi_cmd_pkg::rdata_t   read_data
);
  import spi_cfg_pkg::*;
  import spi_cmd_pkg::*;

  spi_op_e              op;
  logic [CNT_WIDTH-1:0] bit_cnt;
  logic                 run;
  logic                 rise;
  logic                 fall;
  logic                 load;
  logic                 sample_en;
  logic                 sample;

  assign op     = spi_op_e'(cmd_in[OP_BIT]);
  assign sample = rise && sample_en;  // Only rising edges of the receive phase carry data.

  // --------------------
  // Control and timing
  // --------------------

  spi_ctrl_fsm i_ctrl_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vld   (cmd_vld),
    .op        (op),
    .bit_cnt   (bit_cnt),
    .fall      (fall),
    .cmd_rdy   (cmd_rdy),
    .cs_n      (cs_n),
    .run       (run),
    .load      (load),
    .sample_en (sample_en),
    .read_vld  (read_vld)
  );

  spi_bit_timer i_bit_timer (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (run),
    .sclk    (sclk),
    .rise    (rise),
    .fall    (fall),
    .bit_cnt (bit_cnt)
  );

  // --------------------
  // Data path
  // --------------------

  spi_shift_out i_shift_out (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .cmd   (cmd_in),
    .shift (fall),
    .mosi  (mosi)
  );

  spi_shift_in i_shift_in (
    .clk    (clk),
    .rst_n  (rst_n),
    .sample (sample),
    .miso   (miso),
    .data   (read_data)
  );

endmodule

//--- spi_master_properties.sv
`timescale 1ns/1ps

module spi_master_properties (
  input logic clk,
  input logic rst_n,
  input logic cmd_rdy,
  input logic cs_n,
  input logic sclk,
  input logic read_vld
);

  // No new command while a frame is open.
  a_rdy_in_frame: assert property (@(posedge clk) disable iff (!rst_n) !cs_n |-> !cmd_rdy)
    else $error("cmd_rdy high while cs_n is low");

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n) cs_n |-> !sclk)
    else $error("sclk high outside a frame");

  // The read result leaves together with the end of the frame.
  a_vld_at_end: assert property (@(posedge clk) disable iff (!rst_n) read_vld |-> $rose(cs_n))
    else $error("read_vld without cs_n rising");

endmodule

bind spi_master spi_master_properties i_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_rdy  (cmd_rdy),
  .cs_n     (cs_n),
  .sclk     (sclk),
  .read_vld (read_vld)
);

//--- spi_shift_in.sv
`timescale 1ns/1ps

module spi_shift_in (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  sample,
  input  logic                  miso,
  output spi_cmd_pkg::rdata_t   data
);

  // First bit received ends up in the MSB after a full byte.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      data <= '0;
    else if (sample)
      data <= {data[$left(data)-1:0], miso};
  end

endmodule

//--- spi_shift_out.sv
`timescale 1ns/1ps

module spi_shift_out (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load,
  input  spi_cmd_pkg::cmd_t   cmd,
  input  logic                shift,
  output logic                mosi
);
  import spi_cmd_pkg::*;

  cmd_t sreg;

  // --------------------
  // Command shifter
  // --------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sreg <= '0;
    else if (load)
      sreg <= cmd;
    else if (shift)
      sreg <= sreg << 1;  // Zeros trail the command, so mosi rests low.
  end

  // MSB first, valid from the cycle after the load.
  assign mosi = sreg[$left(sreg)];

endmodule

//--- tb.f
spi_cfg_pkg.sv
spi_cmd_pkg.sv
spi_ctrl_fsm.sv
spi_bit_timer.sv
spi_shift_out.sv
spi_shift_in.sv
spi_master.sv
spi_master_properties.sv
tb_spi_master.sv

//--- tb_spi_master.sv
`timescale 1ns/1ps

module tb_spi_master;
  import spi_cfg_pkg::*;
  import spi_cmd_pkg::*;

  localparam int N_CMDS          = 40;
  localparam int CLK_NS          = 8;
  localparam int WATCHDOG_CYCLES = N_CMDS * (26 * SCLK_HALF + 4) * 2 + 500;  // Idle gaps included.

  logic   clk = 1'b0;
  logic   rst_n;
  cmd_t   cmd_in;
  logic   cmd_vld;
  logic   cmd_rdy;
  logic   sclk;
  logic   cs_n;
  logic   mosi;
  logic   miso;
  logic   read_vld;
  rdata_t read_data;

  integer seed;
  int     accepted;
  int     handshakes;
  int     frames;
  int     pending_reads;
  cmd_t   exp_q[$];
  rdata_t exp_read;
  rdata_t model_regs[8];  // Slave register file that serves as the reference model.
  int     sl_cnt;
  cmd_t   sl_bits;
  logic [2:0] rd_addr;
  logic   rd_frame;
  int     cyc;
  int     last_rise;
  logic   have_rise;
  logic   sclk_d;

  spi_master i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  always #(CLK_NS / 2) clk = !clk;

  // --------------------
  // Checks
  // --------------------

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_frame(input cmd_t exp, input cmd_t got);
    if (exp !== got)
    begin
      $display("error at %0t: frame bits %h, expected %h", $time, got, exp);
      stop_run("frame mismatch");
    end
  endtask

  task automatic check_read(input rdata_t exp, input rdata_t got);
    if (exp !== got)
    begin
      $display("error at %0t: read_data %h, expected %h", $time, got, exp);
      stop_run("read data mismatch");
    end
  endtask

  // --------------------
  // SPI slave model
  // --------------------

  always @(negedge cs_n)
  begin
    sl_cnt   = 0;
    sl_bits  = '0;
    rd_frame = 1'b0;
  end

  always @(posedge sclk)
    if (!cs_n)
    begin
      sl_bits = {sl_bits[CMD_WIDTH-2:0], mosi};
      sl_cnt++;
    end

  // Next data bit goes out on each falling edge once the header is in.
  always @(negedge sclk)
    if (!cs_n && sl_cnt >= HDR_BITS && sl_cnt < CMD_WIDTH)
    begin
      if (sl_cnt == HDR_BITS)
      begin
        rd_frame = (sl_bits[HDR_BITS-1] == OP_READ);
        rd_addr  = sl_bits[2:0];
      end
      if (rd_frame)
        miso <= model_regs[rd_addr][READ_WIDTH - 1 - (sl_cnt - HDR_BITS)];
    end

  always @(posedge cs_n)
    if (rst_n)
    begin
      cmd_t exp;
      if (exp_q.size() == 0)
        stop_run("A frame appeared without an accepted command.");
      if (pending_reads != 0)
        stop_run("read_vld did not pulse for the previous read.");
      exp = exp_q.pop_front();
      if (sl_cnt != CMD_WIDTH)
        stop_run($sformatf("A frame carried %0d bits instead of %0d.", sl_cnt, CMD_WIDTH));
      if (exp[OP_BIT] == OP_WRITE)
      begin
        check_frame(exp, sl_bits);
        model_regs[exp[10:8]] = exp[7:0];
      end
      else
      begin
        check_frame({exp[11:8], 8'h00}, {sl_bits[11:8], 8'h00});  // Header only.
        exp_read = model_regs[exp[10:8]];
        pending_reads++;
      end
      frames++;
    end

  // --------------------
  // Monitors on the falling clock edge
  // --------------------

  always @(negedge clk)
    if (rst_n)
    begin
      cyc++;
      if (cmd_vld && cmd_rdy)
      begin
        exp_q.push_back(cmd_in);
        handshakes++;
      end
      if (read_vld)
      begin
        if (pending_reads == 0)
          stop_run("read_vld pulsed without a read frame.");
        check_read(exp_read, read_data);
        pending_reads--;
      end
      if (cs_n)
        have_rise = 1'b0;
      else if (sclk && !sclk_d)
      begin
        if (have_rise && (cyc - last_rise) != 2 * SCLK_HALF)
          stop_run("The sclk period inside a frame was wrong.");
        have_rise = 1'b1;
        last_rise = cyc;
      end
      sclk_d = sclk;
    end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_NS);
    $display("Timeout: the commands did not all complete in time.");
    $display("Some tests failed");
    $fatal(1);
  end

  // --------------------
  // Stimulus
  // --------------------

  initial
  begin
    seed          = 32'h966f;
    rst_n         = 1'b0;
    cmd_in        = '0;
    cmd_vld       = 1'b0;
    miso          = 1'b0;
    accepted      = 0;
    handshakes    = 0;
    frames        = 0;
    pending_reads = 0;
    cyc           = 0;
    last_rise     = 0;
    have_rise     = 1'b0;
    sclk_d        = 1'b0;
    for (int i = 0; i < 8; i++)
      model_regs[i] = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (cs_n !== 1'b1 || sclk !== 1'b0 || cmd_rdy !== 1'b1 || read_vld !== 1'b0
        || mosi !== 1'b0)
      stop_run("Outputs were wrong after reset.");

    while (accepted < N_CMDS)
    begin
      @(posedge clk);
      if (cmd_vld && cmd_rdy)
      begin
        accepted++;
        cmd_vld <= 1'b0;
        if (accepted < N_CMDS && ($random(seed) & 1))
        begin
          cmd_in  <= cmd_t'($random(seed));
          cmd_vld <= 1'b1;
        end
      end
      else if (!cmd_vld && ($random(seed) & 1))
      begin
        cmd_in  <= cmd_t'($random(seed));  // Often offered while the master is busy.
        cmd_vld <= 1'b1;
      end
    end

    wait (frames == N_CMDS);
    repeat (4) @(posedge clk);
    if (frames == handshakes && pending_reads == 0 && exp_q.size() == 0)
    begin
      $display("All tests passed");
      $finish;
    end
    else
      stop_run("Frame count does not match the number of accepted commands.");
  end

endmodule
